// File: source/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data and address width
`define LSU_XLEN 32

// Sequence number width
// Age is compared by signed difference since sqN wraps
`define LSU_SQN_W 6

// Destination tag width
`define LSU_TAG_W 6

// Data memory depth in words
`define LSU_MEM_WORDS 256

`endif

// File: source/lsuPkg.sv
`include "lsu_params.svh"

package lsuPkg;

    // Load and store operations
    typedef enum logic [3:0] {
        LSU_LB  = 4'd0,
        LSU_LH  = 4'd1,
        LSU_LW  = 4'd2,
        LSU_LBU = 4'd3,
        LSU_LHU = 4'd4,
        LSU_FLW = 4'd5,
        LSU_SB  = 4'd6,
        LSU_SH  = 4'd7,
        LSU_SW  = 4'd8,
        LSU_FSW = 4'd9
    } LsuOp;

    // Micro-op from issue
    typedef struct packed {
        logic                  valid;
        LsuOp                  opcode;
        logic [`LSU_XLEN-1:0]  srcA;
        logic [`LSU_XLEN-1:0]  srcB;
        logic [11:0]           imm;
        logic [`LSU_TAG_W-1:0] tagDst;
        logic [`LSU_SQN_W-1:0] sqN;
        logic [`LSU_XLEN-1:0]  pc;
    } ExUop;

    // Address generator output
    typedef struct packed {
        logic                  valid;
        logic [`LSU_XLEN-1:0]  addr;
        logic [`LSU_XLEN-1:0]  data;
        logic [3:0]            wmask;
        logic [1:0]            shamt;
        logic [1:0]            size;
        logic                  signExtend;
        logic                  isLoad;
        logic                  exception;
        logic [`LSU_TAG_W-1:0] tagDst;
        logic [`LSU_SQN_W-1:0] sqN;
        logic [`LSU_XLEN-1:0]  pc;
    } AguUop;

    // Misprediction notice with a one-cycle taken strobe
    typedef struct packed {
        logic                  taken;
        logic [`LSU_SQN_W-1:0] sqN;
    } BranchProv;

    typedef struct packed {
        logic nullCheck;
        logic alignCheck;
    } CheckCfg;

    // Completion record
    typedef struct packed {
        logic                  valid;
        logic                  isLoad;
        logic                  exception;
        logic [`LSU_TAG_W-1:0] tagDst;
        logic [`LSU_SQN_W-1:0] sqN;
        logic [`LSU_XLEN-1:0]  data;
    } LsuResult;

endpackage

// File: source/lsuConfig.sv
`timescale 1ns/1ps

module lsuConfig import lsuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cfgWrite,
    input  logic    cfgAddr,
    input  logic    cfgData,
    output CheckCfg cfg
);

    // Both checks on out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.nullCheck <= 1'b1;
            cfg.alignCheck <= 1'b1;
        end else if (cfgWrite) begin
            // Address 0 selects null check, address 1 the alignment check
            if (cfgAddr) begin
                cfg.alignCheck <= cfgData;
            end else begin
                cfg.nullCheck <= cfgData;
            end
        end
    end

    // An unknown select would silently leave one enable stale
    cfgAddrKnown: assert property (
        @(posedge clk) disable iff (rst)
        cfgWrite |-> !$isunknown({cfgAddr, cfgData})
    ) else $error("config write with unknown address or data");

endmodule

// File: source/addrGen.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module addrGen import lsuPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  ExUop      inUop,
    input  BranchProv branch,
    input  CheckCfg   cfg,
    output AguUop     agu
);

    logic [`LSU_XLEN-1:0]  addr;
    logic [`LSU_SQN_W-1:0] sqDiff;
    logic                  younger;
    logic                  misaligned;
    AguUop                 nextUop;

    assign addr = inUop.srcA + {{(`LSU_XLEN-12){inUop.imm[11]}}, inUop.imm};

    // Sequence numbers wrap, so age is the sign of the difference
    assign sqDiff = inUop.sqN - branch.sqN;
    assign younger = branch.taken && ($signed(sqDiff) > 0);

    always_comb begin
        nextUop.valid = inUop.valid && !younger;
        nextUop.addr = addr;
        nextUop.data = inUop.srcB;
        nextUop.wmask = 4'b0000;
        nextUop.shamt = 2'b00;
        nextUop.size = 2'd2;
        nextUop.signExtend = 1'b0;
        nextUop.isLoad = 1'b1;
        nextUop.tagDst = inUop.tagDst;
        nextUop.sqN = inUop.sqN;
        nextUop.pc = inUop.pc;

        case (inUop.opcode)
            LSU_LB, LSU_LBU: begin
                nextUop.shamt = addr[1:0];
                nextUop.size = 2'd0;
                nextUop.signExtend = (inUop.opcode == LSU_LB);
            end
            LSU_LH, LSU_LHU: begin
                nextUop.shamt = {addr[1], 1'b0};
                nextUop.size = 2'd1;
                nextUop.signExtend = (inUop.opcode == LSU_LH);
            end
            LSU_SB: begin
                nextUop.isLoad = 1'b0;
                nextUop.size = 2'd0;
                nextUop.wmask = 4'b0001 << addr[1:0];
                nextUop.data = inUop.srcB << {addr[1:0], 3'b000};
            end
            LSU_SH: begin
                nextUop.isLoad = 1'b0;
                nextUop.size = 2'd1;
                nextUop.wmask = addr[1] ? 4'b1100 : 4'b0011;
                nextUop.data = addr[1] ? (inUop.srcB << 16) : inUop.srcB;
            end
            LSU_SW, LSU_FSW: begin
                nextUop.isLoad = 1'b0;
                nextUop.wmask = 4'b1111;
            end
            // LW and FLW take the whole word as is
            default: begin
            end
        endcase

        misaligned = ((nextUop.size == 2'd1) && addr[0])
            || ((nextUop.size == 2'd2) && (addr[1:0] != 2'b00));
        nextUop.exception = (cfg.nullCheck && (addr == '0))
            || (cfg.alignCheck && misaligned);
    end

    // Squash happens only here at acceptance
    always_ff @(posedge clk) begin
        agu <= nextUop;
        if (rst) begin
            agu.valid <= 1'b0;
        end
    end

    // A store that reaches memory must touch at least one byte
    storeHasMask: assert property (
        @(posedge clk) disable iff (rst)
        (agu.valid && !agu.isLoad && !agu.exception) |-> (agu.wmask != 4'b0000)
    ) else $error("valid store leaves with empty byte mask");

endmodule

// File: source/dataMemory.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module dataMemory import lsuPkg::*; (
    input  logic                 clk,
    input  AguUop                agu,
    output logic [`LSU_XLEN-1:0] rdata
);

    localparam int IdxW = $clog2(`LSU_MEM_WORDS);

    logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];
    logic [IdxW-1:0]      wordIdx;
    logic                 doWrite;

    // Word bits of the address wrap at the memory depth
    assign wordIdx = agu.addr[2 +: IdxW];
    assign doWrite = agu.valid && !agu.isLoad && !agu.exception;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (agu.wmask[b]) begin
                    mem[wordIdx][8*b +: 8] <= agu.data[8*b +: 8];
                end
            end
        end
        // Registered read on every cycle
        rdata <= mem[wordIdx];
    end

endmodule

// File: source/loadAlign.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module loadAlign import lsuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  AguUop                agu,
    input  logic [`LSU_XLEN-1:0] rdata,
    output LsuResult             result
);

    // Control fields delayed to meet the registered read data
    typedef struct packed {
        logic                  valid;
        logic                  isLoad;
        logic                  exception;
        logic [1:0]            shamt;
        logic [1:0]            size;
        logic                  signExtend;
        logic [`LSU_TAG_W-1:0] tagDst;
        logic [`LSU_SQN_W-1:0] sqN;
    } AlignCtl;

    AlignCtl              ctl;
    logic [`LSU_XLEN-1:0] shifted;
    logic [`LSU_XLEN-1:0] loadData;

    always_ff @(posedge clk) begin
        ctl <= '{valid: agu.valid, isLoad: agu.isLoad, exception: agu.exception,
                 shamt: agu.shamt, size: agu.size, signExtend: agu.signExtend,
                 tagDst: agu.tagDst, sqN: agu.sqN};
        if (rst) begin
            ctl.valid <= 1'b0;
        end
    end

    assign shifted = rdata >> {ctl.shamt, 3'b000};

    always_comb begin
        case (ctl.size)
            2'd0: loadData = {{(`LSU_XLEN-8){ctl.signExtend & shifted[7]}}, shifted[7:0]};
            2'd1: loadData = {{(`LSU_XLEN-16){ctl.signExtend & shifted[15]}}, shifted[15:0]};
            default: loadData = shifted;
        endcase
    end

    // Stores and excepting ops complete with zero data
    always_ff @(posedge clk) begin
        result.valid <= ctl.valid;
        result.isLoad <= ctl.isLoad;
        result.exception <= ctl.exception;
        result.tagDst <= ctl.tagDst;
        result.sqN <= ctl.sqN;
        result.data <= (ctl.isLoad && !ctl.exception) ? loadData : '0;
        if (rst) begin
            result.valid <= 1'b0;
        end
    end

    // Undefined flags here mean the decode upstream went wrong
    resultFlagsKnown: assert property (
        @(posedge clk) disable iff (rst)
        result.valid |-> !$isunknown({result.isLoad, result.exception})
    ) else $error("completion with undefined isLoad and exception");

endmodule

// File: source/loadStoreTop.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module loadStoreTop import lsuPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  ExUop      inUop,
    input  BranchProv branch,
    input  logic      cfgWrite,
    input  logic      cfgAddr,
    input  logic      cfgData,
    output LsuResult  result
);

    CheckCfg              cfg;
    AguUop                agu;
    logic [`LSU_XLEN-1:0] rdata;

    lsuConfig uConfig (
        .clk      (clk),
        .rst      (rst),
        .cfgWrite (cfgWrite),
        .cfgAddr  (cfgAddr),
        .cfgData  (cfgData),
        .cfg      (cfg)
    );

    addrGen uAddrGen (
        .clk    (clk),
        .rst    (rst),
        .inUop  (inUop),
        .branch (branch),
        .cfg    (cfg),
        .agu    (agu)
    );

    dataMemory uMemory (
        .clk   (clk),
        .agu   (agu),
        .rdata (rdata)
    );

    loadAlign uAlign (
        .clk    (clk),
        .rst    (rst),
        .agu    (agu),
        .rdata  (rdata),
        .result (result)
    );

endmodule

// File: sim/tbLoadStore.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module tbLoadStore import lsuPkg::*; ();

    localparam int Cols = 10;
    localparam int MaxVec = 128;
    localparam int CyclesPerVec = 10;
    localparam int SlackCycles = 100;

    // One pending completion
    typedef struct packed {
        logic [31:0]           due;
        logic                  isLoad;
        logic                  exception;
        logic [`LSU_TAG_W-1:0] tagDst;
        logic [`LSU_SQN_W-1:0] sqN;
        logic [`LSU_XLEN-1:0]  data;
    } ExpRecord;

    logic      clk = 1'b0;
    logic      rst;
    ExUop      inUop;
    BranchProv branch;
    logic      cfgWrite;
    logic      cfgAddr;
    logic      cfgData;
    LsuResult  result;

    logic [31:0] vecMem [MaxVec*Cols];
    ExpRecord    expQ[$];
    int          numVec = 0;
    int          errCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    logic        loaded = 1'b0;

    loadStoreTop dut (
        .clk      (clk),
        .rst      (rst),
        .inUop    (inUop),
        .branch   (branch),
        .cfgWrite (cfgWrite),
        .cfgAddr  (cfgAddr),
        .cfgData  (cfgData),
        .result   (result)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic logic isLoadOp(input LsuOp op);
        case (op)
            LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU, LSU_FLW: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Vectors end at the first action word of F
    function automatic int countVectors();
        int n;
        n = 0;
        while (n < MaxVec && !$isunknown(vecMem[n*Cols]) && vecMem[n*Cols] != 32'hF) begin
            n++;
        end
        return n;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        checkCount++;
        if (got !== want) begin
            $display("Error %s got %h expected %h", name, got, want);
            errCount++;
        end
    endtask

    task automatic clearInputs();
        inUop = '0;
        branch = '0;
        cfgWrite = 1'b0;
        cfgAddr = 1'b0;
        cfgData = 1'b0;
    endtask

    // Columns are action, opcode, srcA, srcB, imm, tag, sqN, branch sqN, expect and data
    task automatic driveVector(input int idx);
        logic [31:0] col [Cols];
        ExpRecord    rec;
        int          c;
        for (c = 0; c < Cols; c++) begin
            col[c] = vecMem[idx*Cols + c];
        end
        clearInputs();
        case (col[0][3:0])
            4'h1, 4'h2: begin
                inUop.valid = 1'b1;
                inUop.opcode = LsuOp'(col[1][3:0]);
                inUop.srcA = col[2];
                inUop.srcB = col[3];
                inUop.imm = col[4][11:0];
                inUop.tagDst = col[5][`LSU_TAG_W-1:0];
                inUop.sqN = col[6][`LSU_SQN_W-1:0];
                inUop.pc = 32'h8000_0000 + idx * 4;
                branch.taken = (col[0][3:0] == 4'h2);
                branch.sqN = col[7][`LSU_SQN_W-1:0];
                // Expect 0 marks a squashed op
                if (col[8][1:0] != 2'd0) begin
                    rec.due = cycleCount + 3;
                    rec.isLoad = isLoadOp(LsuOp'(col[1][3:0]));
                    rec.exception = (col[8][1:0] == 2'd2);
                    rec.tagDst = col[5][`LSU_TAG_W-1:0];
                    rec.sqN = col[6][`LSU_SQN_W-1:0];
                    rec.data = col[9];
                    expQ.push_back(rec);
                end
            end
            4'h3: begin
                cfgWrite = 1'b1;
                cfgAddr = col[1][0];
                cfgData = col[2][0];
            end
            default: begin
            end
        endcase
    endtask

    task automatic compareCompletion();
        ExpRecord rec;
        if (expQ.size() == 0) begin
            $display("Completion with tag %h at cycle %0d when none was expected",
                     result.tagDst, cycleCount);
            errCount++;
        end else begin
            rec = expQ.pop_front();
            if (rec.due != cycleCount) begin
                $display("Completion for sqN %h came at cycle %0d instead of cycle %0d",
                         rec.sqN, cycleCount, rec.due);
                errCount++;
            end
            checkValue("result.isLoad", 32'(result.isLoad), 32'(rec.isLoad));
            checkValue("result.exception", 32'(result.exception), 32'(rec.exception));
            checkValue("result.tagDst", 32'(result.tagDst), 32'(rec.tagDst));
            checkValue("result.sqN", 32'(result.sqN), 32'(rec.sqN));
            checkValue("result.data", result.data, rec.data);
        end
    endtask

    // Sampled half a cycle after the edge that registers the result
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            if (result.valid) begin
                compareCompletion();
            end else if (expQ.size() != 0 && expQ[0].due <= cycleCount) begin
                $display("Completion for sqN %h did not arrive at cycle %0d",
                         expQ[0].sqN, expQ[0].due);
                errCount++;
                void'(expQ.pop_front());
            end
        end
    end

    initial begin
        int v;
        rst = 1'b1;
        clearInputs();
        $readmemh("sim/golden_vectors.hex", vecMem);
        numVec = countVectors();
        loaded = 1'b1;
        if (numVec == 0) begin
            $display("No vectors found in the golden file");
            errCount++;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (v = 0; v < numVec; v++) begin
            @(posedge clk);
            #1;
            driveVector(v);
        end
        @(posedge clk);
        #1;
        clearInputs();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        // A few more cycles to catch stray completions
        repeat (5) @(negedge clk);
        $display("Run done: %0d vectors, %0d checks, %0d errors", numVec, checkCount, errCount);
        if (errCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (numVec * CyclesPerVec + SlackCycles) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles",
                 numVec * CyclesPerVec + SlackCycles);
        errCount++;
        $display("Run done: %0d vectors, %0d checks, %0d errors", numVec, checkCount, errCount);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+source
source/lsuPkg.sv
source/lsuConfig.sv
source/addrGen.sv
source/dataMemory.sv
source/loadAlign.sv
source/loadStoreTop.sv
sim/tbLoadStore.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tbLoadStore \
    -f verilog.f \
    -o simLoadStore

output=$(./obj_dir/simLoadStore)
echo "$output"

if grep -qx "TB PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: sim/golden_vectors.hex
// act(0 idle 1 op 2 op+branch 3 cfg F end) op srcA srcB imm tag sqN brSqN exp(0 none 1 ok 2 exc) data
// For cfg lines op is cfgAddr and srcA is cfgData
1 8 00000100 11223344 000 3E 01 00 1 00000000
1 8 00000104 55667788 000 3D 02 00 1 00000000
1 9 00000108 99AABBCC 000 3C 03 00 1 00000000
1 8 00000110 DDEEFF00 FFC 3B 04 00 1 00000000
1 6 00000100 000000A1 000 3A 05 00 1 00000000
1 6 00000100 FFFFFFB2 001 39 06 00 1 00000000
1 6 00000102 000000C3 000 38 07 00 1 00000000
1 6 00000100 000000D4 003 37 08 00 1 00000000
1 2 00000100 00000000 000 36 09 00 1 D4C3B2A1
1 7 00000104 0000E5F6 000 35 0A 00 1 00000000
1 7 00000104 12348899 002 34 0B 00 1 00000000
1 2 00000104 00000000 000 33 0C 00 1 8899E5F6
1 0 00000100 00000000 000 32 0D 00 1 FFFFFFA1
1 3 00000100 00000000 001 31 0E 00 1 000000B2
1 0 00000102 00000000 000 30 0F 00 1 FFFFFFC3
1 3 00000103 00000000 000 2F 10 00 1 000000D4
1 1 00000104 00000000 000 2E 11 00 1 FFFFE5F6
1 4 00000104 00000000 002 2D 12 00 1 00008899
1 1 00000106 00000000 000 2C 13 00 1 FFFF8899
1 7 00000108 00007123 000 2B 14 00 1 00000000
1 1 00000108 00000000 000 2A 15 00 1 00007123
1 0 00000108 00000000 001 29 16 00 1 00000071
1 4 0000010A 00000000 000 28 17 00 1 000099AA
1 5 00000108 00000000 000 27 18 00 1 99AA7123
1 2 00000110 00000000 FFC 26 19 00 1 DDEEFF00
0 0 00000000 00000000 000 00 00 00 0 00000000
1 2 00000000 00000000 000 25 1A 00 2 00000000
1 8 00000000 12345678 000 24 1B 00 2 00000000
1 2 00000101 00000000 000 23 1C 00 2 00000000
1 1 00000103 00000000 000 22 1D 00 2 00000000
1 4 00000102 00000000 000 21 1E 00 1 0000D4C3
1 8 0000010D CAFEF00D 000 20 1F 00 2 00000000
1 7 00000105 00001111 000 1F 20 00 2 00000000
1 2 0000010C 00000000 000 1E 21 00 1 DDEEFF00
1 2 00000104 00000000 000 1D 22 00 1 8899E5F6
1 3 00000004 00000000 FFC 1C 23 00 2 00000000
3 0 00000000 00000000 000 00 00 00 0 00000000
1 8 00000000 0BADF00D 000 1B 24 00 1 00000000
1 2 00000000 00000000 000 1A 25 00 1 0BADF00D
1 2 00000101 00000000 000 19 26 00 2 00000000
3 1 00000000 00000000 000 00 00 00 0 00000000
1 2 00000101 00000000 000 18 27 00 1 D4C3B2A1
1 1 00000103 00000000 000 17 28 00 1 FFFFD4C3
1 8 0000010D CAFEF00D 000 16 29 00 1 00000000
1 2 0000010C 00000000 000 15 2A 00 1 CAFEF00D
1 7 00000105 00001111 000 14 2B 00 1 00000000
1 2 00000106 00000000 000 13 2C 00 1 88991111
0 0 00000000 00000000 000 00 00 00 0 00000000
2 8 00000108 5A5A5A5A 000 11 05 03 0 00000000
1 2 00000108 00000000 000 12 2D 00 1 99AA7123
2 2 00000104 00000000 000 10 3C 3E 1 88991111
2 6 00000108 000000EE 000 0F 01 3E 0 00000000
2 6 00000108 00000077 000 0E 3D 3E 1 00000000
2 2 00000108 00000000 000 0D 20 20 1 99AA7177
0 0 00000000 00000000 000 00 00 00 0 00000000
F 0 00000000 00000000 000 00 00 00 0 00000000
